// File: all.f
+incdir+common
common/shim_pkg.sv
common/cmd_pkg.sv
hw/pingpong_addr.sv
ingress/ingress_ctrl.sv
ingress/cmd_steer.sv
egress/egress_ctrl.sv
hw/shim_top.sv
test/tb_shim.sv

// File: run.sh
#!/bin/sh
# Build and run the shim testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -f all.f --top-module tb_shim -o sim_shim > build.log 2>&1 &&
./obj_dir/sim_shim > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

// File: test/tb_shim.sv
`include "shim_cfg.svh"

module tb_shim;
	timeunit 1ns;
	timeprecision 100ps;
	import shim_pkg::*;
	import cmd_pkg::*;

	localparam int LIMIT = 4000;

	logic clk, rst;
	logic [1:0] dma_wb_valid, dma_wb_last, dma_rb_ready, dma_rb_last;
	line_t dma_wb_data, dma_rb_data, output_data0, output_data1;
	buf_addr_t dma_wb_raddr, dma_rb_waddr;
	logic dma_wb_ren, dma_rb_wen, inst_wen, input_wen0, input_wen1, npu_start;
	logic input_rdy0, input_rdy1, output_rdy0, output_rdy1, output_ren0, output_ren1;
	ben_t dma_rb_ben;
	mrf_data_t mrf_wdata;
	mrf_sel_t mrf_wen;
	mrf_addr_t mrf_waddr;
	inst_data_t inst_wdata;
	inst_addr_t inst_waddr;
	in_data_t input_data0, input_data1;

	// Models and expected NPU writes
	line_t wb_mem [32];
	line_t f0_mem [16];
	line_t f1_mem [16];
	int f0_head, f1_head, f0_len, f1_len;
	logic ret_vld;
	buf_addr_t rd_addr_q;
	logic [2:0] exp_k [64];
	logic [63:0] exp_d [64];
	logic [5:0] exp_a [64];
	mrf_sel_t exp_sel [64];
	logic exp_st [64];
	int exp_t [64];
	int exp_rd, exp_wr, cyc, cur, eg_n;
	logic [31:0] wbm, rbm, id_c, ed_c;
	logic ib, eb, in_wrap, eg_wrap;
	logic [3:0] io, eo;
	logic [5:0] h;
	line_t eg_data;
	logic [15:0] lfsr;
	int err [5];
	string names [5];

	shim_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], lfsr[15]};
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		end
		return v;
	endfunction

	function automatic line_t make_line(input logic [2:0] dest, input logic [2:0] id,
		input logic [5:0] adr, input logic [63:0] pay);
		line_t l;
		l = '0;
		l[2:0] = dest;
		l[5:3] = id;
		l[11:6] = adr;
		l[127:64] = pay;
		return l;
	endfunction

	function automatic line_t cfg_line(input logic [2:0] dest, input logic [31:0] cnt);
		line_t l;
		l = '0;
		l[2:0] = dest;
		l[34:3] = cnt;
		return l;
	endfunction

	// Run limit
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Write buffer, one cycle latency; output FIFOs, show-ahead
	always @(posedge clk) begin
		ret_vld <= rst ? 1'b0 : dma_wb_ren;
		if (dma_wb_ren)
			rd_addr_q <= dma_wb_raddr;
		if (output_ren0)
			f0_head <= f0_head + 1;
		if (output_ren1)
			f1_head <= f1_head + 1;
	end

	always @(negedge clk) begin
		dma_wb_data <= wb_mem[rd_addr_q];
		output_data0 <= f0_mem[f0_head[3:0]];
		output_data1 <= f1_mem[f1_head[3:0]];
		output_rdy0 <= f0_head < f0_len;
		output_rdy1 <= f1_head < f1_len;
	end

	// Header decode of each returned line into the expected queue
	always @(posedge clk) begin
		if (rst) begin
			exp_wr <= 0;
			wbm <= 16;
			rbm <= 16;
		end else if (ret_vld) begin
			case (dma_wb_data[2:0])
				DEST_MRF, DEST_INST, DEST_IN0, DEST_IN1: begin
					exp_k[exp_wr % 64] <= dma_wb_data[2:0];
					exp_sel[exp_wr % 64] <= dma_wb_data[5:3] + 3'd1;
					exp_a[exp_wr % 64] <= dma_wb_data[11:6];
					exp_t[exp_wr % 64] <= cyc + `SHIM_OUT_DELAY;
					exp_st[exp_wr % 64] <= dma_wb_data[2:0] == DEST_INST &&
						32'(dma_wb_data[9:6]) == wbm - 32'd2;
					exp_d[exp_wr % 64] <= (dma_wb_data[2:0] == DEST_INST) ?
						64'(dma_wb_data[127:88]) : dma_wb_data[127:64];
					exp_wr <= exp_wr + 1;
				end
				DEST_CFG_IN: wbm <= dma_wb_data[34:3];
				DEST_CFG_OUT: rbm <= dma_wb_data[34:3];
				default: ;
			endcase
		end
	end

	// Bank and offset models for both buffers
	assign in_wrap = (id_c == wbm - 32'd1) || (io == 4'd15);
	assign eg_wrap = (ed_c == rbm - 32'd1) || (eo == 4'd15);
	assign eg_data = eg_n[0] ? f1_mem[eg_n[4:1]] : f0_mem[eg_n[4:1]];
	assign h = exp_rd[5:0];

	always @(posedge clk) begin
		if (rst) begin
			{ib, io, id_c, eb, eo, ed_c} <= '0;
			exp_rd <= 0;
			eg_n <= 0;
		end else begin
			if (mrf_wen != '0 || inst_wen || input_wen0 || input_wen1)
				exp_rd <= exp_rd + 1;
			if (dma_wb_ren) begin
				ib <= in_wrap ? ~ib : ib;
				io <= in_wrap ? 4'd0 : io + 4'd1;
				id_c <= (id_c == wbm - 32'd1) ? 32'd0 : id_c + 32'd1;
			end
			if (dma_rb_wen) begin
				eb <= eg_wrap ? ~eb : eb;
				eo <= eg_wrap ? 4'd0 : eo + 4'd1;
				ed_c <= (ed_c == rbm - 32'd1) ? 32'd0 : ed_c + 32'd1;
				eg_n <= eg_n + 1;
			end
		end
	end

	// Checks, sampled mid-cycle where registered outputs are stable
	a_rd_addr : assert property (@(negedge clk) disable iff (rst)
		dma_wb_ren |-> dma_wb_raddr == {ib, io} && dma_wb_last == (in_wrap ? {ib, ~ib} : 2'b00))
		else begin
			$display("Error %s: expected %h actual %h", names[cur], {ib, io}, dma_wb_raddr);
			err[cur]++;
		end
	a_rd_last : assert property (@(negedge clk) disable iff (rst)
		!dma_wb_ren |-> dma_wb_last == 2'b00)
		else begin
			$display("Error %s: expected %h actual %h", names[cur], 2'b00, dma_wb_last);
			err[cur]++;
		end
	a_rd_held : assert property (@(negedge clk) disable iff (rst)
		dma_wb_ren |-> input_rdy0 && input_rdy1)
		else begin
			$display("%s: read issued while an input FIFO was not ready", names[cur]);
			err[cur]++;
		end
	a_mrf : assert property (@(negedge clk) disable iff (rst)
		mrf_wen != '0 |-> exp_rd != exp_wr && exp_k[h] == DEST_MRF && mrf_wen == exp_sel[h] &&
		mrf_waddr == exp_a[h] && mrf_wdata == exp_d[h] && cyc == exp_t[h])
		else begin
			$display("Error %s: expected %h actual %h", names[cur], exp_d[h], mrf_wdata);
			err[cur]++;
		end
	a_inst : assert property (@(negedge clk) disable iff (rst)
		inst_wen |-> exp_rd != exp_wr && exp_k[h] == DEST_INST &&
		inst_waddr == exp_a[h][3:0] && 64'(inst_wdata) == exp_d[h] &&
		npu_start == exp_st[h] && cyc == exp_t[h])
		else begin
			$display("Error %s: expected %h actual %h", names[cur], exp_d[h], inst_wdata);
			err[cur]++;
		end
	a_start : assert property (@(negedge clk) disable iff (rst) npu_start |-> inst_wen)
		else begin
			$display("%s: npu_start pulsed without an instruction write", names[cur]);
			err[cur]++;
		end
	a_in0 : assert property (@(negedge clk) disable iff (rst)
		input_wen0 |-> exp_rd != exp_wr && exp_k[h] == DEST_IN0 &&
		input_data0 == exp_d[h] && cyc == exp_t[h])
		else begin
			$display("Error %s: expected %h actual %h", names[cur], exp_d[h], input_data0);
			err[cur]++;
		end
	a_in1 : assert property (@(negedge clk) disable iff (rst)
		input_wen1 |-> exp_rd != exp_wr && exp_k[h] == DEST_IN1 &&
		input_data1 == exp_d[h] && cyc == exp_t[h])
		else begin
			$display("Error %s: expected %h actual %h", names[cur], exp_d[h], input_data1);
			err[cur]++;
		end
	a_rb_write : assert property (@(negedge clk) disable iff (rst)
		dma_rb_wen |-> dma_rb_data == eg_data && dma_rb_ben == '1 && dma_rb_waddr == {eb, eo} &&
		dma_rb_last == (eg_wrap ? {eb, ~eb} : 2'b00) && dma_rb_ready != 2'b00)
		else begin
			$display("Error %s: expected %h actual %h", names[cur], eg_data, dma_rb_data);
			err[cur]++;
		end
	a_rb_idle : assert property (@(negedge clk) disable iff (rst)
		!dma_rb_wen |-> dma_rb_last == 2'b00)
		else begin
			$display("Error %s: expected %h actual %h", names[cur], 2'b00, dma_rb_last);
			err[cur]++;
		end

	task automatic read_lines(input int n, input logic bp);
		int k;
		logic [63:0] r;
		k = 0;
		dma_wb_valid = 2'b11;
		while (k < n) begin
			@(negedge clk);
			if (dma_wb_ren)
				k++;
			if (k == n)
				dma_wb_valid = 2'b00;
			if (bp) begin
				r = rand_bits(2);
				input_rdy0 = r[0];
				input_rdy1 = r[1];
			end
		end
		input_rdy0 = 1'b1;
		input_rdy1 = 1'b1;
	endtask

	// Let every issued read reach the NPU ports
	task automatic wait_idle();
		do begin
			@(negedge clk);
		end while (dma_wb_ren || ret_vld || exp_rd != exp_wr);
	endtask

	task automatic report_test(input int t);
		$display("Test %0d %s: %s", t + 1, names[t], (err[t] == 0) ? "passed" : "failed");
		cur = t + 1;
	endtask

	initial begin
		int fails;
		logic [63:0] r, s;
		names = '{"ingress addressing", "mrf writes", "instruction writes",
			"input fifos", "egress"};
		err = '{0, 0, 0, 0, 0};
		lfsr = 16'd6;
		cyc = 0;
		cur = 0;
		{f0_head, f1_head, f0_len, f1_len} = '0;
		rst = 1'b1;
		dma_wb_valid = 2'b00;
		dma_rb_ready = 2'b00;
		input_rdy0 = 1'b1;
		input_rdy1 = 1'b1;
		dma_wb_data = '0;
		output_data0 = '0;
		output_data1 = '0;
		output_rdy0 = 1'b0;
		output_rdy1 = 1'b0;
		rd_addr_q = '0;
		for (int a = 0; a < 32; a++)
			wb_mem[a] = {4{a[7:0] ^ 8'h5a, 24'h0}};
		wb_mem[0] = cfg_line(DEST_CFG_IN, 32'd5);
		// Ids stay below 7 so that id plus one is a real select
		for (int a = 16; a < 19; a++) begin
			r = rand_bits(64);
			s = rand_bits(9);
			wb_mem[a] = make_line(DEST_MRF, s[2:0] % 3'd7, s[8:3], r);
		end
		r = rand_bits(64);
		wb_mem[19] = make_line(DEST_INST, 3'd0, 6'd3, r);
		r = rand_bits(64);
		wb_mem[20] = make_line(DEST_INST, 3'd0, 6'd1, r);
		repeat (8) @(negedge clk);
		rst = 1'b0;
		// Config line alone, then four more lines close the bank of five
		read_lines(1, 1'b0);
		wait_idle();
		read_lines(4, 1'b0);
		wait_idle();
		report_test(0);
		read_lines(3, 1'b0);
		wait_idle();
		report_test(1);
		read_lines(2, 1'b0);
		wait_idle();
		report_test(2);
		// Twenty line transfer crosses the full bank 0
		wb_mem[0] = cfg_line(DEST_CFG_IN, 32'd20);
		for (int a = 1; a < 20; a++) begin
			s = rand_bits(1);
			r = rand_bits(64);
			wb_mem[a] = make_line(s[0] ? DEST_IN1 : DEST_IN0, 3'd0, 6'd0, r);
		end
		read_lines(1, 1'b0);
		wait_idle();
		read_lines(19, 1'b1);
		wait_idle();
		report_test(3);
		wb_mem[0] = cfg_line(DEST_CFG_OUT, 32'd6);
		read_lines(1, 1'b0);
		wait_idle();
		for (int i = 0; i < 8; i++) begin
			r = rand_bits(64);
			s = rand_bits(64);
			f0_mem[i] = {r, s};
			f1_mem[i] = {s, r};
		end
		f0_len = 8;
		f1_len = 8;
		dma_rb_ready = 2'b11;
		while (eg_n < 10)
			@(negedge clk);
		dma_rb_ready = 2'b00;
		repeat (6) @(negedge clk);
		dma_rb_ready = 2'b11;
		while (eg_n < 16)
			@(negedge clk);
		repeat (4) @(negedge clk);
		if (eg_n != 16 || f0_head != 8 || f1_head != 8) begin
			$display("egress: read buffer writes lost or repeated, %0d writes seen", eg_n);
			err[4]++;
		end
		wait_idle();
		report_test(4);
		fails = 0;
		for (int t = 0; t < 5; t++)
			if (err[t] != 0)
				fails++;
		$display("Tests passed: %0d, failed: %0d", 5 - fails, fails);
		if (fails == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: hw/shim_top.sv
module shim_top (
	input  logic                clk,
	input  logic                rst,
	// Write buffer
	input  logic [1:0]          dma_wb_valid,
	input  shim_pkg::line_t     dma_wb_data,
	output shim_pkg::buf_addr_t dma_wb_raddr,
	output logic [1:0]          dma_wb_last,
	output logic                dma_wb_ren,
	// Read buffer
	input  logic [1:0]          dma_rb_ready,
	output shim_pkg::line_t     dma_rb_data,
	output shim_pkg::buf_addr_t dma_rb_waddr,
	output logic [1:0]          dma_rb_last,
	output logic                dma_rb_wen,
	output shim_pkg::ben_t      dma_rb_ben,
	// Matrix register files
	output cmd_pkg::mrf_data_t  mrf_wdata,
	output cmd_pkg::mrf_sel_t   mrf_wen,
	output cmd_pkg::mrf_addr_t  mrf_waddr,
	// Instruction memory
	output cmd_pkg::inst_data_t inst_wdata,
	output logic                inst_wen,
	output cmd_pkg::inst_addr_t inst_waddr,
	// Input FIFOs
	output cmd_pkg::in_data_t   input_data0,
	output logic                input_wen0,
	input  logic                input_rdy0,
	output cmd_pkg::in_data_t   input_data1,
	output logic                input_wen1,
	input  logic                input_rdy1,
	// Output FIFOs, show-ahead
	input  shim_pkg::line_t     output_data0,
	output logic                output_ren0,
	input  logic                output_rdy0,
	input  shim_pkg::line_t     output_data1,
	output logic                output_ren1,
	input  logic                output_rdy1,
	output logic                npu_start
);
	import shim_pkg::*;

	logic      rd_issued;
	line_cnt_t wb_count;
	line_cnt_t rb_count;

	ingress_ctrl u_ingress (
		.clk          (clk),
		.rst          (rst),
		.dma_wb_valid (dma_wb_valid),
		.input_rdy0   (input_rdy0),
		.input_rdy1   (input_rdy1),
		.wb_count     (wb_count),
		.dma_wb_ren   (dma_wb_ren),
		.dma_wb_raddr (dma_wb_raddr),
		.dma_wb_last  (dma_wb_last),
		.rd_issued    (rd_issued)
	);

	cmd_steer u_steer (
		.clk         (clk),
		.rst         (rst),
		.rd_issued   (rd_issued),
		.dma_wb_data (dma_wb_data),
		.wb_count    (wb_count),
		.rb_count    (rb_count),
		.mrf_wdata   (mrf_wdata),
		.mrf_wen     (mrf_wen),
		.mrf_waddr   (mrf_waddr),
		.inst_wdata  (inst_wdata),
		.inst_wen    (inst_wen),
		.inst_waddr  (inst_waddr),
		.input_data0 (input_data0),
		.input_data1 (input_data1),
		.input_wen0  (input_wen0),
		.input_wen1  (input_wen1),
		.npu_start   (npu_start)
	);

	egress_ctrl u_egress (
		.clk          (clk),
		.rst          (rst),
		.dma_rb_ready (dma_rb_ready),
		.output_data0 (output_data0),
		.output_data1 (output_data1),
		.output_rdy0  (output_rdy0),
		.output_rdy1  (output_rdy1),
		.rb_count     (rb_count),
		.dma_rb_wen   (dma_rb_wen),
		.dma_rb_waddr (dma_rb_waddr),
		.dma_rb_data  (dma_rb_data),
		.dma_rb_ben   (dma_rb_ben),
		.dma_rb_last  (dma_rb_last),
		.output_ren0  (output_ren0),
		.output_ren1  (output_ren1)
	);

endmodule

// File: egress/egress_ctrl.sv
module egress_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  logic [1:0]          dma_rb_ready,
	input  shim_pkg::line_t     output_data0,
	input  shim_pkg::line_t     output_data1,
	input  logic                output_rdy0,
	input  logic                output_rdy1,
	input  shim_pkg::line_cnt_t rb_count,
	output logic                dma_rb_wen,
	output shim_pkg::buf_addr_t dma_rb_waddr,
	output shim_pkg::line_t     dma_rb_data,
	output shim_pkg::ben_t      dma_rb_ben,
	output logic [1:0]          dma_rb_last,
	output logic                output_ren0,
	output logic                output_ren1
);
	import shim_pkg::*;

	logic      src_sel;
	logic      src_rdy;
	logic      issue;
	buf_addr_t wr_addr;
	bank_t     wr_bank;
	logic      wr_wrap;

	// src_sel low means output FIFO 0 is next
	assign src_rdy = src_sel ? output_rdy1 : output_rdy0;
	assign issue   = dma_rb_ready[wr_bank] && src_rdy;

	pingpong_addr u_rb_addr (
		.clk        (clk),
		.rst        (rst),
		.step       (issue),
		.line_count (rb_count),
		.addr       (wr_addr),
		.bank       (wr_bank),
		.wrap       (wr_wrap)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			src_sel     <= 1'b0;
			dma_rb_wen  <= 1'b0;
			dma_rb_ben  <= '0;
			dma_rb_last <= 2'b00;
			output_ren0 <= 1'b0;
			output_ren1 <= 1'b0;
		end else begin
			dma_rb_wen  <= issue;
			dma_rb_ben  <= issue ? '1 : '0;
			// Pop the head that is being written
			output_ren0 <= issue && !src_sel;
			output_ren1 <= issue && src_sel;
			if (issue) begin
				src_sel <= !src_sel;
			end
			if (issue && wr_wrap) begin
				dma_rb_last <= (wr_bank == BANK1) ? 2'b10 : 2'b01;
			end else begin
				dma_rb_last <= 2'b00;
			end
		end
	end

	always_ff @(posedge clk) begin
		dma_rb_waddr <= wr_addr;
		dma_rb_data  <= src_sel ? output_data1 : output_data0;
	end

	a_single_pop : assert property (
		@(posedge clk) disable iff (rst) !(output_ren0 && output_ren1)
	) else $error("egress_ctrl: both output FIFOs popped together");

endmodule

// File: ingress/cmd_steer.sv
`include "shim_cfg.svh"

module cmd_steer (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 rd_issued,
	input  shim_pkg::line_t      dma_wb_data,
	output shim_pkg::line_cnt_t  wb_count,
	output shim_pkg::line_cnt_t  rb_count,
	output cmd_pkg::mrf_data_t   mrf_wdata,
	output cmd_pkg::mrf_sel_t    mrf_wen,
	output cmd_pkg::mrf_addr_t   mrf_waddr,
	output cmd_pkg::inst_data_t  inst_wdata,
	output logic                 inst_wen,
	output cmd_pkg::inst_addr_t  inst_waddr,
	output cmd_pkg::in_data_t    input_data0,
	output cmd_pkg::in_data_t    input_data1,
	output logic                 input_wen0,
	output logic                 input_wen1,
	output logic                 npu_start
);
	import shim_pkg::*;
	import cmd_pkg::*;

	localparam int DLY = `SHIM_OUT_DELAY;
	localparam int LW  = `SHIM_LINE_W;

	logic       data_vld;
	dest_t      dest;
	mrf_sel_t   hdr_id;
	mrf_addr_t  hdr_addr;
	inst_addr_t hdr_iaddr;
	line_cnt_t  hdr_cnt;
	logic       is_mrf, is_inst, is_in0, is_in1;

	// Delay pipeline, stage DLY-1 drives the NPU
	mrf_sel_t   mrf_wen_q   [DLY];
	logic       inst_wen_q  [DLY];
	logic       in_wen0_q   [DLY];
	logic       in_wen1_q   [DLY];
	logic       start_q     [DLY];
	mrf_data_t  mrf_data_q  [DLY];
	mrf_addr_t  mrf_addr_q  [DLY];
	inst_data_t inst_data_q [DLY];
	inst_addr_t inst_addr_q [DLY];
	in_data_t   in_data0_q  [DLY];
	in_data_t   in_data1_q  [DLY];

	// Header fields
	assign dest      = dest_t'(dma_wb_data[`SHIM_DEST_W-1:0]);
	assign hdr_id    = dma_wb_data[`SHIM_HDR_ID_LSB +: `SHIM_MRF_IDW];
	assign hdr_addr  = dma_wb_data[`SHIM_HDR_ADR_LSB +: `SHIM_MRF_AW];
	assign hdr_iaddr = hdr_addr[`SHIM_INST_AW-1:0];
	assign hdr_cnt   = dma_wb_data[`SHIM_HDR_CNT_LSB +: `SHIM_CNT_W];

	assign is_mrf  = data_vld && (dest == DEST_MRF);
	assign is_inst = data_vld && (dest == DEST_INST);
	assign is_in0  = data_vld && (dest == DEST_IN0);
	assign is_in1  = data_vld && (dest == DEST_IN1);

	always_ff @(posedge clk) begin
		if (rst) begin
			data_vld <= 1'b0;
			wb_count <= line_cnt_t'(`SHIM_BANK_LINES);
			rb_count <= line_cnt_t'(`SHIM_BANK_LINES);
			for (int k = 0; k < DLY; k++) begin
				mrf_wen_q[k]  <= '0;
				inst_wen_q[k] <= 1'b0;
				in_wen0_q[k]  <= 1'b0;
				in_wen1_q[k]  <= 1'b0;
				start_q[k]    <= 1'b0;
			end
		end else begin
			data_vld <= rd_issued;
			if (data_vld && dest == DEST_CFG_IN) begin
				wb_count <= hdr_cnt;
			end
			if (data_vld && dest == DEST_CFG_OUT) begin
				rb_count <= hdr_cnt;
			end
			mrf_wen_q[0]  <= is_mrf ? hdr_id + mrf_sel_t'(1) : '0;
			inst_wen_q[0] <= is_inst;
			in_wen0_q[0]  <= is_in0;
			in_wen1_q[0]  <= is_in1;
			// Second-to-last instruction of the program kicks off the NPU
			start_q[0]    <= is_inst && (line_cnt_t'(hdr_iaddr) == wb_count - line_cnt_t'(2));
			for (int k = 1; k < DLY; k++) begin
				mrf_wen_q[k]  <= mrf_wen_q[k-1];
				inst_wen_q[k] <= inst_wen_q[k-1];
				in_wen0_q[k]  <= in_wen0_q[k-1];
				in_wen1_q[k]  <= in_wen1_q[k-1];
				start_q[k]    <= start_q[k-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (is_mrf) begin
			mrf_data_q[0] <= dma_wb_data[LW-1 -: `SHIM_MRF_W];
			mrf_addr_q[0] <= hdr_addr;
		end
		if (is_inst) begin
			inst_data_q[0] <= dma_wb_data[LW-1 -: `SHIM_INST_W];
			inst_addr_q[0] <= hdr_iaddr;
		end
		if (is_in0) begin
			in_data0_q[0] <= dma_wb_data[LW-1 -: `SHIM_IN_W];
		end
		if (is_in1) begin
			in_data1_q[0] <= dma_wb_data[LW-1 -: `SHIM_IN_W];
		end
		for (int k = 1; k < DLY; k++) begin
			mrf_data_q[k]  <= mrf_data_q[k-1];
			mrf_addr_q[k]  <= mrf_addr_q[k-1];
			inst_data_q[k] <= inst_data_q[k-1];
			inst_addr_q[k] <= inst_addr_q[k-1];
			in_data0_q[k]  <= in_data0_q[k-1];
			in_data1_q[k]  <= in_data1_q[k-1];
		end
	end

	assign mrf_wen     = mrf_wen_q[DLY-1];
	assign mrf_wdata   = mrf_data_q[DLY-1];
	assign mrf_waddr   = mrf_addr_q[DLY-1];
	assign inst_wen    = inst_wen_q[DLY-1];
	assign inst_wdata  = inst_data_q[DLY-1];
	assign inst_waddr  = inst_addr_q[DLY-1];
	assign input_wen0  = in_wen0_q[DLY-1];
	assign input_wen1  = in_wen1_q[DLY-1];
	assign input_data0 = in_data0_q[DLY-1];
	assign input_data1 = in_data1_q[DLY-1];
	assign npu_start   = start_q[DLY-1];

	a_one_target : assert property (
		@(posedge clk) disable iff (rst)
		$onehot0({|mrf_wen, inst_wen, input_wen0, input_wen1})
	) else $error("cmd_steer: more than one NPU write class active");

endmodule

// File: ingress/ingress_ctrl.sv
module ingress_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  logic [1:0]          dma_wb_valid,
	input  logic                input_rdy0,
	input  logic                input_rdy1,
	input  shim_pkg::line_cnt_t wb_count,
	output logic                dma_wb_ren,
	output shim_pkg::buf_addr_t dma_wb_raddr,
	output logic [1:0]          dma_wb_last,
	output logic                rd_issued
);
	import shim_pkg::*;

	logic      issue;
	buf_addr_t rd_addr;
	bank_t     rd_bank;
	logic      rd_wrap;

	// Read only while the bank holds data and both input FIFOs can take it
	assign issue = dma_wb_valid[rd_bank] && input_rdy0 && input_rdy1;

	pingpong_addr u_wb_addr (
		.clk        (clk),
		.rst        (rst),
		.step       (issue),
		.line_count (wb_count),
		.addr       (rd_addr),
		.bank       (rd_bank),
		.wrap       (rd_wrap)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			dma_wb_ren  <= 1'b0;
			dma_wb_last <= 2'b00;
		end else begin
			dma_wb_ren <= issue;
			// Hand the finished bank back to the host
			if (issue && rd_wrap) begin
				dma_wb_last <= (rd_bank == BANK1) ? 2'b10 : 2'b01;
			end else begin
				dma_wb_last <= 2'b00;
			end
		end
	end

	always_ff @(posedge clk) begin
		dma_wb_raddr <= rd_addr;
	end

	// Data follows one cycle after the strobe
	assign rd_issued = dma_wb_ren;

endmodule

// File: hw/pingpong_addr.sv
`include "shim_cfg.svh"

module pingpong_addr (
	input  logic                clk,
	input  logic                rst,
	input  logic                step,
	input  shim_pkg::line_cnt_t line_count,
	output shim_pkg::buf_addr_t addr,
	output shim_pkg::bank_t     bank,
	output logic                wrap
);
	import shim_pkg::*;

	localparam int BANK_LINES = `SHIM_BANK_LINES;

	buf_addr_t offset;
	line_cnt_t done_cnt;
	logic      count_hit;
	logic      bank_end;

	// This step finishes the transfer
	assign count_hit = (done_cnt == line_count - line_cnt_t'(1));
	// This step uses the last line of the bank
	assign bank_end  = (offset == buf_addr_t'(BANK_LINES - 1));
	assign wrap      = count_hit || bank_end;

	assign addr = (bank == BANK1) ? buf_addr_t'(BANK_LINES) + offset : offset;

	always_ff @(posedge clk) begin
		if (rst) begin
			bank     <= BANK0;
			offset   <= '0;
			done_cnt <= '0;
		end else if (step) begin
			if (wrap) begin
				bank   <= (bank == BANK0) ? BANK1 : BANK0;
				offset <= '0;
			end else begin
				offset <= offset + buf_addr_t'(1);
			end
			// A full bank without a finished transfer keeps counting
			if (count_hit) begin
				done_cnt <= '0;
			end else begin
				done_cnt <= done_cnt + line_cnt_t'(1);
			end
		end
	end

	a_count_nonzero : assert property (
		@(posedge clk) disable iff (rst) step |-> (line_count != '0)
	) else $error("pingpong_addr: step with zero line count");

	a_offset_in_bank : assert property (
		@(posedge clk) disable iff (rst) offset < buf_addr_t'(BANK_LINES)
	) else $error("pingpong_addr: offset left the bank");

endmodule

// File: common/cmd_pkg.sv
`include "shim_cfg.svh"

package cmd_pkg;

	// Destination code in the low header bits
	// Codes 0 and 7 are not listed and are dropped by the decoder
	typedef enum logic [`SHIM_DEST_W-1:0] {
		DEST_MRF     = 3'd1,
		DEST_INST    = 3'd2,
		DEST_IN0     = 3'd3,
		DEST_IN1     = 3'd4,
		DEST_CFG_IN  = 3'd5,
		DEST_CFG_OUT = 3'd6
	} dest_t;

	// MRF select, id plus one, zero means idle
	typedef logic [`SHIM_MRF_IDW-1:0] mrf_sel_t;

	// Header address fields
	typedef logic [`SHIM_MRF_AW-1:0]  mrf_addr_t;
	typedef logic [`SHIM_INST_AW-1:0] inst_addr_t;

	// NPU payloads, all cut from the top of a line
	typedef logic [`SHIM_MRF_W-1:0]  mrf_data_t;
	typedef logic [`SHIM_INST_W-1:0] inst_data_t;
	typedef logic [`SHIM_IN_W-1:0]   in_data_t;

endpackage

// File: common/shim_pkg.sv
`include "shim_cfg.svh"

package shim_pkg;

	// One write or read buffer line
	typedef logic [`SHIM_LINE_W-1:0] line_t;

	// Address into either buffer, covers both banks
	typedef logic [`SHIM_BUF_AW-1:0] buf_addr_t;

	// One enable per byte of a line
	typedef logic [`SHIM_LINE_W/8-1:0] ben_t;

	// Transfer length in lines
	typedef logic [`SHIM_CNT_W-1:0] line_cnt_t;

	// Ping-pong bank select
	typedef enum logic {
		BANK0 = 1'b0,
		BANK1 = 1'b1
	} bank_t;

endpackage

// File: common/shim_cfg.svh
`ifndef SHIM_CFG_SVH
`define SHIM_CFG_SVH

// Buffer geometry
`define SHIM_LINE_W      128
`define SHIM_BANK_LINES  16
`define SHIM_BUF_AW      5
`define SHIM_CNT_W       32

// NPU port widths
`define SHIM_MRF_W       64
`define SHIM_INST_W      40
`define SHIM_IN_W        64
`define SHIM_MRF_AW      6
`define SHIM_MRF_IDW     3
`define SHIM_INST_AW     4

// Header layout: dest, then MRF id, then address; payload sits at the top
`define SHIM_DEST_W      3
`define SHIM_HDR_ID_LSB  `SHIM_DEST_W
`define SHIM_HDR_ADR_LSB (`SHIM_DEST_W + `SHIM_MRF_IDW)
`define SHIM_HDR_CNT_LSB `SHIM_DEST_W

// Register stages from a returned line to the NPU write ports
`define SHIM_OUT_DELAY   7

`endif
